/* card_defs.svh */
// Card geometry, glyph cell placement and colour constants for the card overlay

`ifndef CARD_DEFS_SVH
`define CARD_DEFS_SVH

// --------------------------------------------------
// Card rectangle
// --------------------------------------------------
// Left and top edge in screen pixels
`define CARD_XPOS   20
`define CARD_YPOS   30

// Span from the left or top edge to the opposite edge
`define CARD_WIDTH  56
`define CARD_HEIGHT 80

// --------------------------------------------------
// Rank glyph cell inside the card
// --------------------------------------------------
`define GLYPH_XOFF  5
`define GLYPH_YOFF  5
`define GLYPH_W     8
`define GLYPH_H     9

// --------------------------------------------------
// Colours with 4 bits each of red, green and blue
// --------------------------------------------------
`define COLOR_WHITE 12'hFFF
`define COLOR_BLACK 12'h000
`define COLOR_RED   12'hF00

`endif

/* card_overlay.sv */
// Card overlay top joining the plain VGA ports to the card registers and painter
`timescale 1ns/1ns
`default_nettype none

module card_overlay
    import card_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    // Card register write port
    input  logic   card_wr,
    input  rank_t  card_rank_in,
    input  suit_t  card_suit_in,
    // Incoming pixel stream
    input  coord_t hcount_in,
    input  coord_t vcount_in,
    input  logic   hsync_in,
    input  logic   vsync_in,
    input  logic   hblnk_in,
    input  logic   vblnk_in,
    input  rgb_t   rgb_in,
    // Outgoing pixel stream, one cycle later
    output coord_t hcount_out,
    output coord_t vcount_out,
    output logic   hsync_out,
    output logic   vsync_out,
    output logic   hblnk_out,
    output logic   vblnk_out,
    output rgb_t   rgb_out
);

    rank_t card_rank;
    suit_t card_suit;

    vga_if vga_in ();
    vga_if vga_out ();

    // --------------------------------------------------
    // Stream in
    // --------------------------------------------------
    assign vga_in.hcount = hcount_in;
    assign vga_in.vcount = vcount_in;
    assign vga_in.hsync  = hsync_in;
    assign vga_in.vsync  = vsync_in;
    assign vga_in.hblnk  = hblnk_in;
    assign vga_in.vblnk  = vblnk_in;
    assign vga_in.rgb    = rgb_in;

    card_regs u_card_regs (
        .clk          (clk),
        .rst          (rst),
        .card_wr      (card_wr),
        .card_rank_in (card_rank_in),
        .card_suit_in (card_suit_in),
        .rank         (card_rank),
        .suit         (card_suit)
    );

    card_painter u_card_painter (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (vga_in.snk),
        .vga_out (vga_out.src),
        .rank    (card_rank),
        .suit    (card_suit)
    );

    // --------------------------------------------------
    // Stream out
    // --------------------------------------------------
    assign hcount_out = vga_out.hcount;
    assign vcount_out = vga_out.vcount;
    assign hsync_out  = vga_out.hsync;
    assign vsync_out  = vga_out.vsync;
    assign hblnk_out  = vga_out.hblnk;
    assign vblnk_out  = vga_out.vblnk;
    assign rgb_out    = vga_out.rgb;

endmodule

`default_nettype wire

/* card_painter.sv */
// Card painter drawing border, body and rank glyph over the pixel stream
`timescale 1ns/1ns
`default_nettype none

`include "card_defs.svh"

module card_painter
    import card_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    vga_if.snk    vga_in,
    vga_if.src    vga_out,
    input  rank_t rank,
    input  suit_t suit
);

    coord_t     rel_x;
    coord_t     rel_y;
    logic       in_card;
    logic       on_border;
    logic       in_glyph;
    logic [3:0] glyph_row;
    logic [2:0] glyph_col;
    logic       glyph_bit;
    rgb_t       suit_color;
    rgb_t       rgb_nxt;

    // --------------------------------------------------
    // Card geometry
    // --------------------------------------------------
    assign rel_x = vga_in.hcount - coord_t'(`CARD_XPOS);
    assign rel_y = vga_in.vcount - coord_t'(`CARD_YPOS);

    // Pixels left of or above the card wrap to large offsets
    assign in_card = (rel_x <= coord_t'(`CARD_WIDTH)) &&
                     (rel_y <= coord_t'(`CARD_HEIGHT));

    // Both edges are part of the card
    assign on_border = (rel_x == '0) || (rel_x == coord_t'(`CARD_WIDTH)) ||
                       (rel_y == '0) || (rel_y == coord_t'(`CARD_HEIGHT));

    assign in_glyph = (rel_x >= coord_t'(`GLYPH_XOFF)) &&
                      (rel_x <  coord_t'(`GLYPH_XOFF + `GLYPH_W)) &&
                      (rel_y >= coord_t'(`GLYPH_YOFF)) &&
                      (rel_y <  coord_t'(`GLYPH_YOFF + `GLYPH_H));

    // Position inside the glyph cell
    assign glyph_col = 3'(rel_x - coord_t'(`GLYPH_XOFF));
    assign glyph_row = 4'(rel_y - coord_t'(`GLYPH_YOFF));

    glyph_rom u_glyph_rom (
        .rank  (rank),
        .row   (glyph_row),
        .col   (glyph_col),
        .pixel (glyph_bit)
    );

    // Glyph colour by suit
    always_comb begin
        case (suit)
            SUIT_SPADES:   suit_color = `COLOR_BLACK;
            SUIT_CLUBS:    suit_color = `COLOR_BLACK;
            SUIT_HEARTS:   suit_color = `COLOR_RED;
            SUIT_DIAMONDS: suit_color = `COLOR_RED;
            default:       suit_color = `COLOR_BLACK;
        endcase
    end

    // --------------------------------------------------
    // Pixel colour select
    // --------------------------------------------------
    always_comb begin
        if (rank == RANK_NONE || !in_card) begin
            rgb_nxt = vga_in.rgb;
        end else if (on_border) begin
            rgb_nxt = `COLOR_BLACK;
        end else if (in_glyph && glyph_bit) begin
            rgb_nxt = suit_color;
        end else begin
            rgb_nxt = `COLOR_WHITE;
        end
    end

    // Output stage keeps timing and colour aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* card_pkg.sv */
// Shared pixel coordinate, colour, rank and suit types for the card overlay
`default_nettype none

package card_pkg;

    // Pixel counter as produced by the VGA timing generator
    typedef logic [10:0] coord_t;

    // 12-bit colour with red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Ranks that have a glyph, plus the hidden card
    typedef enum logic [3:0] {
        RANK_NONE = 4'd0,
        RANK_ACE  = 4'd1,
        RANK_2    = 4'd2,
        RANK_3    = 4'd3,
        RANK_4    = 4'd4,
        RANK_5    = 4'd5,
        RANK_6    = 4'd6,
        RANK_7    = 4'd7,
        RANK_8    = 4'd8,
        RANK_9    = 4'd9
    } rank_t;

    // Spades and clubs draw black, hearts and diamonds red
    typedef enum logic [1:0] {
        SUIT_SPADES   = 2'd0,
        SUIT_CLUBS    = 2'd1,
        SUIT_HEARTS   = 2'd2,
        SUIT_DIAMONDS = 2'd3
    } suit_t;

endpackage

`default_nettype wire

/* card_regs.sv */
// Card register block holding the shown rank and suit, loaded by a write strobe
`timescale 1ns/1ns
`default_nettype none

module card_regs
    import card_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  card_wr,
    input  rank_t card_rank_in,
    input  suit_t card_suit_in,
    output rank_t rank,
    output suit_t suit
);

    rank_t rank_clean;

    // Ranks without a glyph are stored as a hidden card
    always_comb begin
        if (card_rank_in > RANK_9) begin
            rank_clean = RANK_NONE;
        end else begin
            rank_clean = card_rank_in;
        end
    end

    // --------------------------------------------------
    // Card registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rank <= RANK_NONE;
            suit <= SUIT_SPADES;
        end else if (card_wr) begin
            rank <= rank_clean;
            suit <= card_suit_in;
        end
    end

endmodule

`default_nettype wire

/* card_trace.txt */
# W rank suit  (decimal; writes the card register)
# P hcount vcount hsync vsync hblnk vblnk rgb_in rgb_expected  (counts decimal, colours hex)
# No card written yet, everything passes through
P 40 60 0 0 0 0 123 123
P 5 5 1 0 1 0 ABC ABC
# Five of spades, edges black, body white
W 5 0
P 20 60 0 0 0 0 5A5 000
P 76 60 0 1 0 1 5A5 000
P 40 30 1 1 0 0 5A5 000
P 40 110 0 0 1 1 5A5 000
P 50 80 1 0 0 1 5A5 FFF
P 25 35 0 0 0 0 5A5 000
P 77 60 0 0 0 0 5A5 5A5
P 40 111 1 1 1 1 5A5 5A5
# Ace of hearts, cross bar on glyph row 4
W 1 2
P 25 39 0 0 0 0 333 F00
P 31 39 1 0 1 0 333 F00
P 32 39 0 1 0 1 333 FFF
P 27 38 0 0 0 0 333 FFF
P 25 38 1 1 0 0 333 F00
P 28 40 0 0 1 1 333 FFF
# Rank 0 hides the card
W 0 3
P 50 80 0 0 0 0 0F0 0F0
W 1 3
P 31 39 0 0 0 0 0F0 F00
# Rank 12 is stored as hidden
W 12 2
P 50 80 1 0 0 0 0F0 0F0
P 20 60 0 0 0 1 0F0 0F0

/* glyph_rom.sv */
// Rank glyph table returning one bitmap pixel for a row and column of the cell
`timescale 1ns/1ns
`default_nettype none

`include "card_defs.svh"

module glyph_rom
    import card_pkg::*;
(
    input  rank_t      rank,
    input  logic [3:0] row,
    input  logic [2:0] col,
    output logic       pixel
);

    logic [71:0] bitmap;
    logic [6:0]  bit_idx;

    // --------------------------------------------------
    // Bitmaps with one byte per row and top row first
    // --------------------------------------------------
    // Leftmost column is the MSB of each row byte
    always_comb begin
        case (rank)
            RANK_ACE: bitmap = 72'hFE_82_82_82_FE_82_82_82_82;
            RANK_2:   bitmap = 72'hF8_08_08_08_F8_80_80_80_F8;
            RANK_3:   bitmap = 72'hFC_04_04_04_FC_04_04_04_FC;
            RANK_4:   bitmap = 72'h40_40_40_40_7E_04_04_04_04;
            RANK_5:   bitmap = 72'hFC_80_80_80_FC_04_04_04_FC;
            RANK_6:   bitmap = 72'hFC_80_80_80_FC_84_84_84_FC;
            // Two-pixel diagonal stroke under the top bar
            RANK_7:   bitmap = 72'hFF_03_06_0C_18_30_60_C0_00;
            RANK_8:   bitmap = 72'hFE_82_82_82_FE_82_82_82_FE;
            RANK_9:   bitmap = 72'hFE_82_82_82_FE_02_02_02_FE;
            default:  bitmap = '0;
        endcase
    end

    // Row times eight plus column
    assign bit_idx = {row, col};

    // Rows below the cell read as background
    always_comb begin
        if (row < `GLYPH_H) begin
            pixel = bitmap[7'd71 - bit_idx];
        end else begin
            pixel = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the card overlay testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary -f src.f --top-module tb_card_overlay -o tb_card_overlay_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_card_overlay_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "No result found in $LOG"
    exit 1
fi
exit 0

/* src.f */
+incdir+.
card_pkg.sv
vga_if.sv
card_regs.sv
glyph_rom.sv
card_painter.sv
card_overlay.sv
tb_card_overlay.sv

/* tb_card_overlay.sv */
// Trace-driven testbench for the card overlay, checking colour and timing one cycle later
`timescale 1ns/1ns
`default_nettype none

module tb_card_overlay
    import card_pkg::*;
();

    localparam int RESET_TIMEOUT = 40;
    localparam int MAX_LINES     = 500;

    logic   clk = 1'b0;
    logic   rst;
    logic   card_wr;
    rank_t  card_rank_in;
    suit_t  card_suit_in;
    coord_t hcount_in;
    coord_t vcount_in;
    logic   hsync_in;
    logic   vsync_in;
    logic   hblnk_in;
    logic   vblnk_in;
    rgb_t   rgb_in;
    coord_t hcount_out;
    coord_t vcount_out;
    logic   hsync_out;
    logic   vsync_out;
    logic   hblnk_out;
    logic   vblnk_out;
    rgb_t   rgb_out;

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    card_overlay dut (
        .clk          (clk),
        .rst          (rst),
        .card_wr      (card_wr),
        .card_rank_in (card_rank_in),
        .card_suit_in (card_suit_in),
        .hcount_in    (hcount_in),
        .vcount_in    (vcount_in),
        .hsync_in     (hsync_in),
        .vsync_in     (vsync_in),
        .hblnk_in     (hblnk_in),
        .vblnk_in     (vblnk_in),
        .rgb_in       (rgb_in),
        .hcount_out   (hcount_out),
        .vcount_out   (vcount_out),
        .hsync_out    (hsync_out),
        .vsync_out    (vsync_out),
        .hblnk_out    (hblnk_out),
        .vblnk_out    (vblnk_out),
        .rgb_out      (rgb_out)
    );

    // 8 ns clock period
    always #4 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic compare_rgb(input string name, input rgb_t got, input rgb_t exp);
        logic [11:0] got_v;
        logic [11:0] exp_v;
        got_v = got;
        exp_v = exp;
        checks++;
        if (got_v !== exp_v) begin
            errors++;
            $display("Error: %s expected 0x%03h got 0x%03h", name, exp_v, got_v);
        end
    endtask

    task automatic compare_coord(input string name, input coord_t got, input coord_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s expected 0x%03h got 0x%03h", name, exp, got);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s expected 0x%0h got 0x%0h", name, exp, got);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic write_card(input int r, input int s);
        @(posedge clk);
        card_wr      <= 1'b1;
        card_rank_in <= rank_t'(4'(r));
        card_suit_in <= suit_t'(2'(s));
        @(posedge clk);
        card_wr      <= 1'b0;
    endtask

    // Drive one pixel, then check it after the register edge
    task automatic apply_pixel(input int hc, input int vc, input int hs, input int vs,
                               input int hb, input int vb, input int rgb_i, input int rgb_e);
        @(posedge clk);
        hcount_in <= coord_t'(hc);
        vcount_in <= coord_t'(vc);
        hsync_in  <= hs[0];
        vsync_in  <= vs[0];
        hblnk_in  <= hb[0];
        vblnk_in  <= vb[0];
        rgb_in    <= rgb_t'(12'(rgb_i));
        @(posedge clk);
        @(negedge clk);
        compare_rgb("rgb_out", rgb_out, rgb_t'(12'(rgb_e)));
        compare_coord("hcount_out", hcount_out, coord_t'(hc));
        compare_coord("vcount_out", vcount_out, coord_t'(vc));
        compare_bit("hsync_out", hsync_out, hs[0]);
        compare_bit("vsync_out", vsync_out, vs[0]);
        compare_bit("hblnk_out", hblnk_out, hb[0]);
        compare_bit("vblnk_out", vblnk_out, vb[0]);
    endtask

    task automatic wait_reset_release(output bit released);
        int cycles;
        released = 1'b0;
        cycles   = 0;
        while (!released && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (!rst) begin
                released = 1'b1;
            end
        end
    endtask

    task automatic run_trace();
        int    fd;
        int    code;
        int    n;
        int    lines;
        bit    done;
        string line;
        int    a, b, c, d, e, f, g, h;
        fd = $fopen("card_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file card_trace.txt");
        end else begin
            lines = 0;
            done  = 1'b0;
            while (!done && lines < MAX_LINES) begin
                code = $fgets(line, fd);
                lines++;
                if (code == 0) begin
                    done = 1'b1;
                end else if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                    // Comment or blank line
                end else if (line[0] == "W") begin
                    n = $sscanf(line, "W %d %d", a, b);
                    if (n != 2) begin
                        errors++;
                        $display("Malformed write line %0d in the trace", lines);
                    end else begin
                        write_card(a, b);
                    end
                end else if (line[0] == "P") begin
                    n = $sscanf(line, "P %d %d %b %b %b %b %h %h", a, b, c, d, e, f, g, h);
                    if (n != 8) begin
                        errors++;
                        $display("Malformed pixel line %0d in the trace", lines);
                    end else begin
                        apply_pixel(a, b, c, d, e, f, g, h);
                    end
                end else begin
                    errors++;
                    $display("Unrecognised line %0d in the trace", lines);
                end
            end
            if (!done) begin
                errors++;
                $display("Trace longer than %0d lines, rest not read", MAX_LINES);
            end
            $fclose(fd);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        bit released;
        card_wr      = 1'b0;
        card_rank_in = RANK_NONE;
        card_suit_in = SUIT_SPADES;
        hcount_in    = '0;
        vcount_in    = '0;
        hsync_in     = 1'b0;
        vsync_in     = 1'b0;
        hblnk_in     = 1'b0;
        vblnk_in     = 1'b0;
        rgb_in       = '0;

        wait_reset_release(released);
        if (released) begin
            run_trace();
        end else begin
            timeouts++;
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vga_if.sv */
// VGA pixel stream bundle carrying timing counters, sync, blanking and colour
`timescale 1ns/1ns
`default_nettype none

interface vga_if
    import card_pkg::*;
();

    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;

    // Producer side of the stream
    modport src (output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);

    // Consumer side of the stream
    modport snk (input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);

endinterface

`default_nettype wire
